//--- td_pkg.sv
`default_nettype none

package td_pkg;

    // ---------------------------------------------------------------------
    // step phases and unit states

    typedef enum logic [2:0] {
        REST,
        INIT,
        SUMMON_DETECT,
        SUMMON_PLACE,
        MARCH,
        PURSE,
        INCOME,
        FINISH
    } step_phase_e;

    typedef enum logic [2:0] {
        NONE,
        MOVE,
        WINDUP,
        STRIKE,
        RECOVER
    } unit_state_e;

    typedef logic [1:0]  unit_type_t;
    typedef logic [9:0]  x_pos_t;
    typedef logic [11:0] hp_t;
    typedef logic [14:0] money_t;
    typedef logic [2:0]  purse_level_t;

    typedef struct packed {
        logic [11:0] hp;
        logic [8:0]  atk;
        logic [3:0]  cooldown;
        logic [4:0]  speed;
        logic [7:0]  range;
    } unit_stats_t;

    typedef struct packed {
        logic        exist;
        unit_type_t  utype;
        x_pos_t      x;
        unit_state_e state;
        logic [3:0]  state_cnt;
    } unit_t;

    // ---------------------------------------------------------------------
    // game tables

    localparam unit_stats_t UNIT_STATS [4] = '{
        '{hp: 12'd100,  atk: 9'd30,  cooldown: 4'd1, speed: 5'd10, range: 8'd20},
        '{hp: 12'd400,  atk: 9'd80,  cooldown: 4'd2, speed: 5'd5,  range: 8'd30},
        '{hp: 12'd300,  atk: 9'd60,  cooldown: 4'd3, speed: 5'd8,  range: 8'd100},
        '{hp: 12'd1000, atk: 9'd200, cooldown: 4'd4, speed: 5'd4,  range: 8'd40}
    };

    localparam money_t UNIT_COST [4] = '{15'd50, 15'd100, 15'd200, 15'd400};

    // level 7 has no upgrade
    localparam money_t PURSE_UPGRADE_COST [8] = '{
        15'd40, 15'd80, 15'd160, 15'd280, 15'd400, 15'd560, 15'd800, 15'd0
    };
    localparam money_t PURSE_MAX [8] = '{
        15'd100, 15'd200, 15'd400, 15'd600, 15'd800, 15'd1000, 15'd1200, 15'd1500
    };
    localparam money_t PURSE_INCOME [8] = '{
        15'd1, 15'd2, 15'd2, 15'd3, 15'd4, 15'd5, 15'd5, 15'd5
    };

    localparam x_pos_t ARMY_SPAWN_X = 10'd570;
    localparam x_pos_t TOWER_E_X    = 10'd70;   // enemy tower face

endpackage

`default_nettype wire

//--- step_if.sv
`timescale 1ns/1ns
`default_nettype none

interface step_if #(
    parameter int NUM_SLOTS = 8
);

    td_pkg::step_phase_e          phase;
    logic [$clog2(NUM_SLOTS)-1:0] slot_idx;
    logic                         slot_last;   // scan sits on the final slot
    logic                         placed;      // unit written this cycle
    logic                         place_idle;  // no valid affordable summon

    modport sequencer (
        output phase,
        output slot_idx,
        input  slot_last,
        input  placed,
        input  place_idle
    );

    // army table side
    modport army (
        input  phase,
        input  slot_idx,
        output slot_last,
        output place_idle
    );

    modport purse (
        input  phase,
        input  placed
    );

endinterface

`default_nettype wire

//--- click_latch.sv
`timescale 1ns/1ns
`default_nettype none

module click_latch (
    input  wire                 clk_25MHz,
    input  wire                 rst,
    input  wire [3:0]           summon_click,
    input  wire                 upgrade_click,
    step_if.purse               step,
    output logic                summon_valid,
    output td_pkg::unit_type_t  summon_type,
    output logic                upgrade_req
);

    logic [3:0]         summon_req;     // sticky button bits
    td_pkg::unit_type_t low_type;
    logic               summon_take;
    logic               upgrade_take;

    assign summon_take  = (step.phase == td_pkg::SUMMON_DETECT);
    assign upgrade_take = (step.phase == td_pkg::PURSE);

    // lowest set request wins
    always_comb begin
        low_type = 2'd0;
        for (int i = 3; i >= 0; i--) begin
            if (summon_req[i]) begin
                low_type = td_pkg::unit_type_t'(i);
            end
        end
    end

    always_ff @(posedge clk_25MHz or posedge rst) begin
        if (rst) begin
            summon_req   <= 4'b0;
            upgrade_req  <= 1'b0;
            summon_valid <= 1'b0;
            summon_type  <= 2'd0;
        end else begin
            // a click in the clearing cycle still sets its bit
            summon_req  <= summon_click | (summon_take ? 4'b0 : summon_req);
            upgrade_req <= upgrade_click | (upgrade_take ? 1'b0 : upgrade_req);
            if (summon_take) begin
                summon_valid <= |summon_req;    // held through SUMMON_PLACE
                summon_type  <= low_type;
            end
        end
    end

endmodule

`default_nettype wire

//--- step_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module step_sequencer #(
    parameter int NUM_SLOTS = 8
) (
    input  wire         clk_25MHz,
    input  wire         rst,
    input  wire         start,
    input  wire         frame_tick,
    step_if.sequencer   step,
    output logic        step_done
);

    localparam int IDX_W = $clog2(NUM_SLOTS);

    td_pkg::step_phase_e phase;
    td_pkg::step_phase_e phase_next;
    logic [IDX_W-1:0]    idx;

    assign step.phase    = phase;
    assign step.slot_idx = idx;
    assign step_done     = (phase == td_pkg::FINISH);

    always_comb begin
        phase_next = phase;
        case (phase)
            td_pkg::REST: begin
                if (frame_tick) begin
                    phase_next = td_pkg::SUMMON_DETECT;
                end
            end
            td_pkg::INIT:          phase_next = td_pkg::REST;
            td_pkg::SUMMON_DETECT: phase_next = td_pkg::SUMMON_PLACE;
            td_pkg::SUMMON_PLACE: begin
                if (step.placed || step.slot_last || step.place_idle) begin
                    phase_next = td_pkg::MARCH;
                end
            end
            td_pkg::MARCH: begin
                if (step.slot_last) begin
                    phase_next = td_pkg::PURSE;
                end
            end
            td_pkg::PURSE:  phase_next = td_pkg::INCOME;
            td_pkg::INCOME: phase_next = td_pkg::FINISH;
            td_pkg::FINISH: phase_next = td_pkg::REST;
            default:        phase_next = td_pkg::REST;
        endcase
        if (start) begin
            phase_next = td_pkg::INIT;  // from any phase
        end
    end

    always_ff @(posedge clk_25MHz or posedge rst) begin
        if (rst) begin
            phase <= td_pkg::REST;
            idx   <= '0;
        end else begin
            phase <= phase_next;
            if (phase_next != phase) begin
                idx <= '0;  // fresh scan on phase entry
            end else if (phase == td_pkg::SUMMON_PLACE || phase == td_pkg::MARCH) begin
                idx <= idx + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- army_table.sv
`timescale 1ns/1ns
`default_nettype none

module army_table #(
    parameter int          NUM_SLOTS     = 8,
    parameter td_pkg::hp_t TOWER_HP_INIT = 12'd4000
) (
    input  wire                 clk_25MHz,
    input  wire                 rst,
    step_if.army                step,
    input  wire                 summon_valid,
    input  wire td_pkg::unit_type_t summon_type,
    input  wire                 affordable,
    output td_pkg::hp_t         tower_hp,
    output logic [3:0]          unit_count,
    output logic                place_ok
);

    td_pkg::unit_t       slots [NUM_SLOTS];
    td_pkg::unit_t       cur;
    td_pkg::unit_t       marched;
    td_pkg::unit_t       spawn;
    td_pkg::unit_stats_t st;
    logic [10:0]         strike_line;
    logic                in_range;
    logic                strike;
    td_pkg::hp_t         tower_hit;

    assign cur = slots[step.slot_idx];
    assign st  = td_pkg::UNIT_STATS[cur.utype];

    assign step.slot_last  = (step.slot_idx == NUM_SLOTS - 1);
    assign step.place_idle = !(summon_valid && affordable);
    assign place_ok = (step.phase == td_pkg::SUMMON_PLACE) && summon_valid
                      && affordable && !cur.exist;

    assign spawn = '{exist: 1'b1, utype: summon_type, x: td_pkg::ARMY_SPAWN_X,
                     state: td_pkg::MOVE, state_cnt: 4'd0};

    // x - range at or below the tower face
    assign strike_line = 11'(td_pkg::TOWER_E_X) + 11'(st.range);
    assign in_range    = (11'(cur.x) <= strike_line);

    assign tower_hit = (td_pkg::hp_t'(st.atk) >= tower_hp) ? 12'd0
                     : tower_hp - td_pkg::hp_t'(st.atk);

    // ---------------------------------------------------------------------
    // per-slot march and attack cycle
    always_comb begin
        marched = cur;
        strike  = 1'b0;
        case (cur.state)
            td_pkg::MOVE: begin
                if (in_range) begin
                    marched.state     = td_pkg::WINDUP;
                    marched.state_cnt = 4'd0;
                end else begin
                    marched.x = cur.x - 10'(st.speed);
                end
            end
            td_pkg::WINDUP: begin
                if (cur.state_cnt == st.cooldown) begin
                    marched.state     = td_pkg::STRIKE;
                    marched.state_cnt = 4'd0;
                end else begin
                    marched.state_cnt = cur.state_cnt + 1'b1;
                end
            end
            td_pkg::STRIKE: begin
                strike            = cur.exist;
                marched.state     = td_pkg::RECOVER;
                marched.state_cnt = 4'd0;
            end
            td_pkg::RECOVER: begin
                if (cur.state_cnt == st.cooldown) begin
                    marched.state     = td_pkg::MOVE;   // re-checks range next step
                    marched.state_cnt = 4'd0;
                end else begin
                    marched.state_cnt = cur.state_cnt + 1'b1;
                end
            end
            default: begin
                marched.state     = td_pkg::MOVE;
                marched.state_cnt = 4'd0;
            end
        endcase
    end

    always_ff @(posedge clk_25MHz or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                slots[i] <= '0;
            end
            tower_hp <= TOWER_HP_INIT;
        end else begin
            case (step.phase)
                td_pkg::INIT: begin
                    for (int i = 0; i < NUM_SLOTS; i++) begin
                        slots[i] <= '0;
                    end
                    tower_hp <= TOWER_HP_INIT;
                end
                td_pkg::SUMMON_PLACE: begin
                    if (place_ok) begin
                        slots[step.slot_idx] <= spawn;
                    end
                end
                td_pkg::MARCH: begin
                    if (cur.exist) begin
                        slots[step.slot_idx] <= marched;
                    end
                    if (strike) begin
                        tower_hp <= tower_hit;  // saturates at 0
                    end
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        unit_count = 4'd0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            unit_count = unit_count + 4'(slots[i].exist);
        end
    end

endmodule

`default_nettype wire

//--- purse_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module purse_ctrl (
    input  wire                     clk_25MHz,
    input  wire                     rst,
    step_if.purse                   step,
    input  wire                     summon_valid,
    input  wire td_pkg::unit_type_t summon_type,
    input  wire                     upgrade_req,
    output logic                    affordable,
    output logic                    can_upgrade,
    output td_pkg::money_t          money,
    output td_pkg::purse_level_t    purse_level
);

    td_pkg::money_t unit_cost;
    td_pkg::money_t upgrade_cost;
    td_pkg::money_t money_cap;
    logic [15:0]    income_sum;     // one spare bit for the cap compare

    assign unit_cost    = td_pkg::UNIT_COST[summon_type];
    assign upgrade_cost = td_pkg::PURSE_UPGRADE_COST[purse_level];
    assign money_cap    = td_pkg::PURSE_MAX[purse_level];

    assign affordable  = summon_valid && (money >= unit_cost);
    assign can_upgrade = (purse_level != 3'd7) && (money >= upgrade_cost);

    assign income_sum = {1'b0, money} + {1'b0, td_pkg::PURSE_INCOME[purse_level]};

    always_ff @(posedge clk_25MHz or posedge rst) begin
        if (rst) begin
            money       <= 15'd0;
            purse_level <= 3'd0;
        end else begin
            case (step.phase)
                td_pkg::INIT: begin
                    money       <= 15'd0;
                    purse_level <= 3'd0;
                end
                td_pkg::SUMMON_PLACE: begin
                    if (step.placed) begin
                        money <= money - unit_cost;
                    end
                end
                td_pkg::PURSE: begin
                    if (upgrade_req && can_upgrade) begin
                        money       <= money - upgrade_cost;
                        purse_level <= purse_level + 1'b1;
                    end
                end
                td_pkg::INCOME: begin
                    if (income_sum > {1'b0, money_cap}) begin
                        money <= money_cap;
                    end else begin
                        money <= income_sum[14:0];
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- game_engine.sv
`timescale 1ns/1ns
`default_nettype none

module game_engine #(
    parameter int          NUM_SLOTS     = 8,
    parameter td_pkg::hp_t TOWER_HP_INIT = 12'd4000
) (
    input  wire                     clk_25MHz,
    input  wire                     rst,
    input  wire                     start,
    input  wire                     frame_tick,
    input  wire [3:0]               summon_click,
    input  wire                     upgrade_click,
    output td_pkg::money_t          money,
    output td_pkg::purse_level_t    purse_level,
    output logic                    can_upgrade,
    output td_pkg::hp_t             tower_hp,
    output logic [3:0]              unit_count,
    output logic                    step_done,
    output logic                    game_win
);

    step_if #(.NUM_SLOTS(NUM_SLOTS)) step ();

    logic               summon_valid;
    td_pkg::unit_type_t summon_type;
    logic               upgrade_req;
    logic               affordable;
    logic               place_ok;

    assign step.placed = place_ok;

    step_sequencer #(
        .NUM_SLOTS(NUM_SLOTS)
    ) step_sequencer_inst (
        .clk_25MHz (clk_25MHz),
        .rst       (rst),
        .start     (start),
        .frame_tick(frame_tick),
        .step      (step.sequencer),
        .step_done (step_done)
    );

    click_latch click_latch_inst (
        .clk_25MHz    (clk_25MHz),
        .rst          (rst),
        .summon_click (summon_click),
        .upgrade_click(upgrade_click),
        .step         (step.purse),
        .summon_valid (summon_valid),
        .summon_type  (summon_type),
        .upgrade_req  (upgrade_req)
    );

    army_table #(
        .NUM_SLOTS    (NUM_SLOTS),
        .TOWER_HP_INIT(TOWER_HP_INIT)
    ) army_table_inst (
        .clk_25MHz   (clk_25MHz),
        .rst         (rst),
        .step        (step.army),
        .summon_valid(summon_valid),
        .summon_type (summon_type),
        .affordable  (affordable),
        .tower_hp    (tower_hp),
        .unit_count  (unit_count),
        .place_ok    (place_ok)
    );

    purse_ctrl purse_ctrl_inst (
        .clk_25MHz   (clk_25MHz),
        .rst         (rst),
        .step        (step.purse),
        .summon_valid(summon_valid),
        .summon_type (summon_type),
        .upgrade_req (upgrade_req),
        .affordable  (affordable),
        .can_upgrade (can_upgrade),
        .money       (money),
        .purse_level (purse_level)
    );

    assign game_win = step_done && (tower_hp == 12'd0);    // seen once per step

endmodule

`default_nettype wire

//--- game_engine_properties.sv
`timescale 1ns/1ns
`default_nettype none

module game_engine_properties (
    input wire                       clk_25MHz,
    input wire                       rst,
    input wire                       start,
    input wire                       step_done,
    input wire td_pkg::money_t       money,
    input wire td_pkg::purse_level_t purse_level,
    input wire td_pkg::hp_t          tower_hp
);

    int fail_count = 0;     // failed properties so far

    done_one_cycle: assert property (@(posedge clk_25MHz) disable iff (rst)
        step_done |=> !step_done)
        else begin
            fail_count++;
            $error("step_done held longer than one cycle");
        end

    money_capped: assert property (@(posedge clk_25MHz) disable iff (rst)
        money <= td_pkg::PURSE_MAX[purse_level])
        else begin
            fail_count++;
            $error("money above the purse cap");
        end

    // tower is restored two cycles after start (INIT in between)
    hp_no_rise: assert property (@(posedge clk_25MHz) disable iff (rst)
        (tower_hp > $past(tower_hp)) |-> $past(start, 2))
        else begin
            fail_count++;
            $error("tower hit points rose outside INIT");
        end

    level_step: assert property (@(posedge clk_25MHz) disable iff (rst)
        (purse_level != $past(purse_level))
            |-> (purse_level == $past(purse_level) + 3'd1) || (purse_level == 3'd0))
        else begin
            fail_count++;
            $error("purse level jumped");
        end

endmodule

bind game_engine game_engine_properties game_engine_properties_inst (
    .clk_25MHz  (clk_25MHz),
    .rst        (rst),
    .start      (start),
    .step_done  (step_done),
    .money      (money),
    .purse_level(purse_level),
    .tower_hp   (tower_hp)
);

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS  = 40,
    parameter int RST_CYCLES = 4
) (
    output logic clk_25MHz,
    output logic rst
);

    initial begin
        clk_25MHz = 1'b0;
        forever #(PERIOD_NS / 2) clk_25MHz = ~clk_25MHz;
    end

    initial begin
        rst = 1'b1;
        #(RST_CYCLES * PERIOD_NS + 5) rst = 1'b0;   // just past the 4th rising edge
    end

endmodule

`default_nettype wire

//--- tb_game_engine.sv
`timescale 1ns/1ns
`default_nettype none

module tb_game_engine;

    localparam int TOWER_HP = 4000;

    typedef struct {
        bit                   start;
        bit [3:0]             clicks;
        bit                   upg;
        td_pkg::money_t       exp_money;
        td_pkg::purse_level_t exp_level;
        logic [3:0]           exp_count;
        td_pkg::hp_t          exp_hp;
        bit                   exp_win;
        bit                   exp_can_upg;
    } entry_t;

    logic clk_25MHz, rst, start, frame_tick, upgrade_click;
    logic [3:0] summon_click;
    td_pkg::money_t money;
    td_pkg::purse_level_t purse_level;
    td_pkg::hp_t tower_hp;
    logic [3:0] unit_count;
    logic can_upgrade, step_done, game_win;

    entry_t table_q [$];
    int errors = 0;
    int watch_cycles = 0;
    bit [31:0] lfsr = 32'h16d06ba7;

    // reference model state
    int m, lv, hp;
    bit ex [8];
    int ty [8], x [8], cnt [8];
    td_pkg::unit_state_e us [8];

    tb_clock_gen clk_gen_inst (.clk_25MHz(clk_25MHz), .rst(rst));

    game_engine #(.NUM_SLOTS(8), .TOWER_HP_INIT(12'(TOWER_HP))) game_engine_inst (
        .clk_25MHz(clk_25MHz), .rst(rst), .start(start), .frame_tick(frame_tick),
        .summon_click(summon_click), .upgrade_click(upgrade_click), .money(money),
        .purse_level(purse_level), .can_upgrade(can_upgrade), .tower_hp(tower_hp),
        .unit_count(unit_count), .step_done(step_done), .game_win(game_win)
    );

    function automatic bit next_bit();
        bit b;
        b = lfsr[0];
        lfsr = (lfsr >> 1) ^ (b ? 32'h80200003 : 32'h0);
        return b;
    endfunction

    task automatic add_steps(input int n, input bit s, input bit [3:0] c, input bit u);
        entry_t e;
        e = '{default: 0};
        e.start = s;
        e.clicks = c;
        e.upg = u;
        for (int i = 0; i < n; i++) begin
            table_q.push_back(e);
            e.start = 1'b0;     // start only on the first
        end
    endtask

    // ------------------------------------------------------------------------
    // reference model of one game step
    task automatic model_step(input bit s, input bit [3:0] c, input bit u);
        int t;
        int free;
        td_pkg::unit_stats_t sts;
        if (s) begin
            m = 0;
            lv = 0;
            hp = TOWER_HP;
            for (int i = 0; i < 8; i++) begin
                ex[i] = 1'b0;
            end
        end
        if (c != 4'b0) begin
            t = 3;
            for (int i = 3; i >= 0; i--) begin
                if (c[i]) begin
                    t = i;  // lowest clicked type
                end
            end
            free = -1;
            for (int i = 7; i >= 0; i--) begin
                if (!ex[i]) begin
                    free = i;
                end
            end
            if (free >= 0 && m >= int'(td_pkg::UNIT_COST[t])) begin
                ex[free] = 1'b1;
                ty[free] = t;
                x[free] = int'(td_pkg::ARMY_SPAWN_X);
                us[free] = td_pkg::MOVE;
                cnt[free] = 0;
                m -= int'(td_pkg::UNIT_COST[t]);
            end
        end
        for (int i = 0; i < 8; i++) begin
            if (!ex[i]) continue;
            sts = td_pkg::UNIT_STATS[ty[i]];
            case (us[i])
                td_pkg::MOVE: begin
                    if (x[i] - int'(sts.range) <= int'(td_pkg::TOWER_E_X)) begin
                        us[i] = td_pkg::WINDUP;
                        cnt[i] = 0;
                    end else begin
                        x[i] -= int'(sts.speed);
                    end
                end
                td_pkg::STRIKE: begin
                    hp = (hp > int'(sts.atk)) ? hp - int'(sts.atk) : 0;
                    us[i] = td_pkg::RECOVER;
                    cnt[i] = 0;
                end
                default: begin  // windup and recover
                    if (cnt[i] == int'(sts.cooldown)) begin
                        us[i] = (us[i] == td_pkg::WINDUP) ? td_pkg::STRIKE : td_pkg::MOVE;
                        cnt[i] = 0;
                    end else begin
                        cnt[i]++;
                    end
                end
            endcase
        end
        if (u && lv < 7 && m >= int'(td_pkg::PURSE_UPGRADE_COST[lv])) begin
            m -= int'(td_pkg::PURSE_UPGRADE_COST[lv]);
            lv++;
        end
        m += int'(td_pkg::PURSE_INCOME[lv]);
        if (m > int'(td_pkg::PURSE_MAX[lv])) begin
            m = int'(td_pkg::PURSE_MAX[lv]);
        end
    endtask

    task automatic apply_entry(input int k, input entry_t e);
        int waited;
        bit ok;
        @(posedge clk_25MHz) #5;
        if (e.start) begin
            start = 1'b1;
            @(posedge clk_25MHz) #5 start = 1'b0;
            @(posedge clk_25MHz) #5;
        end
        summon_click = e.clicks;
        upgrade_click = e.upg;
        @(posedge clk_25MHz) #5;
        summon_click = 4'b0;
        upgrade_click = 1'b0;
        frame_tick = 1'b1;
        @(posedge clk_25MHz) #5 frame_tick = 1'b0;
        waited = 0;
        while (!step_done && waited < 100) begin
            @(posedge clk_25MHz) #1;
            waited++;
        end
        ok = step_done;
        assert (step_done) else begin
            $display("step %0d: step_done never came", k);
            errors++;
        end
        assert (money == e.exp_money) else begin
            $display("error @%0t: step %0d money %0d, expected %0d", $time, k, money,
                     e.exp_money);
            errors++;
            ok = 1'b0;
        end
        assert (purse_level == e.exp_level) else begin
            $display("error @%0t: step %0d level %0d, expected %0d", $time, k,
                     purse_level, e.exp_level);
            errors++;
            ok = 1'b0;
        end
        assert (can_upgrade == e.exp_can_upg) else begin
            $display("error @%0t: step %0d can_upgrade %0b, expected %0b", $time, k,
                     can_upgrade, e.exp_can_upg);
            errors++;
            ok = 1'b0;
        end
        assert (unit_count == e.exp_count) else begin
            $display("error @%0t: step %0d units %0d, expected %0d", $time, k,
                     unit_count, e.exp_count);
            errors++;
            ok = 1'b0;
        end
        assert (tower_hp == e.exp_hp && game_win == e.exp_win) else begin
            $display("error @%0t: step %0d tower %0d win %0b, expected %0d %0b", $time, k,
                     tower_hp, game_win, e.exp_hp, e.exp_win);
            errors++;
            ok = 1'b0;
        end
        $display("step %0d: %s (money %0d level %0d units %0d tower %0d)", k,
                 ok ? "ok" : "mismatch", money, purse_level, unit_count, tower_hp);
    endtask

    initial begin
        int cnt_ex;
        int prop_fails;
        start = 1'b0;
        frame_tick = 1'b0;
        summon_click = 4'b0;
        upgrade_click = 1'b0;

        add_steps(4, 1'b1, 4'b0000, 1'b0);     // income from zero
        add_steps(1, 1'b0, 4'b0001, 1'b0);     // too poor to summon
        add_steps(1, 1'b0, 4'b0000, 1'b1);     // too poor to upgrade
        add_steps(110, 1'b0, 4'b0000, 1'b0);   // reach the level-0 cap
        add_steps(1, 1'b0, 4'b0110, 1'b0);     // lowest clicked is type 1
        add_steps(45, 1'b0, 4'b0000, 1'b0);
        add_steps(1, 1'b0, 4'b0000, 1'b1);     // upgrade to level 1
        add_steps(320, 1'b0, 4'b1001, 1'b0);   // fill the table, tower falls
        add_steps(20, 1'b0, 4'b0001, 1'b1);
        for (int i = 0; i < 40; i++) begin
            add_steps(1, 1'b0, {next_bit(), next_bit(), next_bit(), next_bit()}, next_bit());
        end
        add_steps(6, 1'b1, 4'b0000, 1'b0);     // restart mid-game

        for (int i = 0; i < table_q.size(); i++) begin
            model_step(table_q[i].start, table_q[i].clicks, table_q[i].upg);
            cnt_ex = 0;
            for (int j = 0; j < 8; j++) begin
                cnt_ex += int'(ex[j]);
            end
            table_q[i].exp_money = td_pkg::money_t'(m);
            table_q[i].exp_level = td_pkg::purse_level_t'(lv);
            table_q[i].exp_count = 4'(cnt_ex);
            table_q[i].exp_hp = td_pkg::hp_t'(hp);
            table_q[i].exp_win = (hp == 0);
            table_q[i].exp_can_upg = (lv < 7) && (m >= int'(td_pkg::PURSE_UPGRADE_COST[lv]));
        end
        watch_cycles = table_q.size() * 600;

        wait (!rst);
        for (int i = 0; i < table_q.size(); i++) begin
            apply_entry(i, table_q[i]);
        end

        prop_fails = game_engine_inst.game_engine_properties_inst.fail_count;
        $display("steps run %0d, errors %0d, property failures %0d", table_q.size(), errors,
                 prop_fails);
        if (errors == 0 && prop_fails == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (watch_cycles > 0);
        repeat (watch_cycles) @(posedge clk_25MHz);
        $display("watchdog: the run did not finish in the allowed time");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
td_pkg.sv
step_if.sv
click_latch.sv
step_sequencer.sv
army_table.sv
purse_ctrl.sv
game_engine.sv
game_engine_properties.sv
tb_clock_gen.sv
tb_game_engine.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert -Wno-fatal
TOP       ?= tb_game_engine
RTL_TOP   ?= game_engine
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^SIMULATION PASSED$$"

clean:
	rm -rf $(OBJ_DIR)
